// ==== common/imuldiv_pkg.sv ====
// ------------------------------
// shared types and constants for the
// iterative multiply/divide unit
// ------------------------------

package imuldiv_pkg;

  // ------------------------------
  // operation select
  // ------------------------------

  // one bit picks the engine
  typedef enum logic {
    fn_mul = 1'b0,
    fn_div = 1'b1
  } imuldiv_fn_e;

  // ------------------------------
  // request and response words
  // ------------------------------

  // for fn_mul a and b are the factors
  // for fn_div a is the dividend, b the divisor
  typedef struct packed {
    imuldiv_fn_e fn;
    logic [31:0] a;
    logic [31:0] b;
  } imuldiv_req_t;

  // remainder sits in the upper half
  typedef struct packed {
    logic [31:0] rem;
    logic [31:0] quo;
  } div_result_t;

  // same 64 bits, read as a product or as rem/quo
  typedef union packed {
    logic signed [63:0] product;
    div_result_t        div;
  } imuldiv_resp_u;

  // ------------------------------
  // iteration counts
  // ------------------------------

  // bit 0 of the multiplier is handled on the load edge
  localparam int unsigned mul_iters = 31;

  // one quotient bit per cycle
  localparam int unsigned div_iters = 32;

endpackage

// ==== mul/int_mul_iterative.sv ====
// ------------------------------
// iterative signed multiplier
// shift-and-add over magnitudes
// ------------------------------

module int_mul_iterative import imuldiv_pkg::*; (
  input  logic               clk,
  input  logic               reset,

  input  logic [31:0]        a,
  input  logic [31:0]        b,
  input  logic               req_val,
  output logic               req_rdy,

  output logic signed [63:0] result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e      state;
  logic [5:0]  count;

  logic        req_fire;
  logic        resp_fire;
  logic        load_en;
  logic        calc_en;

  logic        sign_a;
  logic        sign_b;
  logic [31:0] a_mag;
  logic [31:0] b_mag;

  // multiplicand shifts left, multiplier shifts right
  logic [63:0] mcand_q;
  logic [31:0] mplier_q;
  logic [63:0] acc_q;
  logic        sign_a_q;
  logic        sign_b_q;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // ------------------------------
  // datapath
  // ------------------------------

  // two's complement magnitudes of the operands
  assign sign_a = a[31];
  assign sign_b = b[31];
  assign a_mag  = sign_a ? (~a + 32'd1) : a;
  assign b_mag  = sign_b ? (~b + 32'd1) : b;

  always_ff @(posedge clk) begin
    if (load_en) begin
      // bit 0 of b is consumed here, so the shifters start one step ahead
      mcand_q  <= {31'b0, a_mag, 1'b0};
      mplier_q <= b_mag >> 1;
      acc_q    <= b_mag[0] ? {32'b0, a_mag} : 64'd0;
      sign_a_q <= sign_a;
      sign_b_q <= sign_b;
    end else if (calc_en) begin
      // add the shifted multiplicand when the current bit is set
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // negate when exactly one operand was negative
  assign result = (sign_a_q ^ sign_b_q) ? (~acc_q + 64'd1) : acc_q;

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= 6'd0;
    end else begin
      case (state)
        st_idle: begin
          if (req_fire) begin
            state <= st_calc;
            count <= 6'd0;
          end
        end
        st_calc: begin
          // last add/shift step moves on to done
          if (count == 6'(mul_iters - 1)) begin
            state <= st_done;
          end else begin
            count <= count + 6'd1;
          end
        end
        st_done: begin
          // hold the product until it is taken
          if (resp_fire) begin
            state <= st_idle;
            count <= 6'd0;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // handshake and datapath enables per state
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    load_en  = 1'b0;
    calc_en  = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        load_en = req_fire;
      end
      st_calc: begin
        calc_en = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// ==== div/int_div_iterative.sv ====
// ------------------------------
// iterative signed restoring divider
// quotient and remainder, divide-by-zero handling
// ------------------------------

module int_div_iterative import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic        req_val,
  output logic        req_rdy,

  output div_result_t result,
  output logic        resp_val,
  input  logic        resp_rdy
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_fix,
    st_done
  } state_e;

  state_e      state;
  logic [5:0]  count;

  logic        req_fire;
  logic        resp_fire;
  logic        load_en;
  logic        calc_en;
  logic        fix_en;

  logic        sign_a;
  logic        sign_b;
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic        div_zero;

  // partial remainder, dividend/quotient shifter and divisor magnitude
  logic [31:0] rem_q;
  logic [31:0] quo_q;
  logic [31:0] divisor_q;
  logic        sign_a_q;
  logic        sign_b_q;

  // one restoring step
  logic [32:0] shifted;
  logic [32:0] diff;
  logic        q_bit;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // ------------------------------
  // datapath
  // ------------------------------

  assign sign_a   = a[31];
  assign sign_b   = b[31];
  assign a_mag    = sign_a ? (~a + 32'd1) : a;
  assign b_mag    = sign_b ? (~b + 32'd1) : b;
  assign div_zero = (b == 32'd0);

  // next dividend bit enters the remainder, then try the subtract
  assign shifted = {rem_q, quo_q[31]};
  assign diff    = shifted - {1'b0, divisor_q};
  // no borrow means the divisor fits
  assign q_bit   = ~diff[32];

  always_ff @(posedge clk) begin
    if (load_en) begin
      divisor_q <= b_mag;
      sign_a_q  <= sign_a;
      sign_b_q  <= sign_b;
      if (div_zero) begin
        // defined result: all-ones quotient, dividend as remainder
        rem_q <= a;
        quo_q <= '1;
      end else begin
        rem_q <= 32'd0;
        quo_q <= a_mag;
      end
    end else if (calc_en) begin
      // restore by keeping the unsubtracted value
      rem_q <= q_bit ? diff[31:0] : shifted[31:0];
      quo_q <= {quo_q[30:0], q_bit};
    end else if (fix_en) begin
      // quotient negative when signs differ
      if (sign_a_q ^ sign_b_q) begin
        quo_q <= ~quo_q + 32'd1;
      end
      // remainder follows the dividend
      if (sign_a_q) begin
        rem_q <= ~rem_q + 32'd1;
      end
    end
  end

  assign result.rem = rem_q;
  assign result.quo = quo_q;

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= 6'd0;
    end else begin
      case (state)
        st_idle: begin
          if (req_fire) begin
            // zero divisor skips the iterations
            state <= div_zero ? st_done : st_calc;
            count <= 6'd0;
          end
        end
        st_calc: begin
          if (count == 6'(div_iters - 1)) begin
            state <= st_fix;
          end else begin
            count <= count + 6'd1;
          end
        end
        st_fix: begin
          state <= st_done;
        end
        st_done: begin
          if (resp_fire) begin
            state <= st_idle;
            count <= 6'd0;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_comb begin
    req_rdy  = (state == st_idle);
    resp_val = (state == st_done);
    load_en  = (state == st_idle) && req_fire;
    calc_en  = (state == st_calc);
    fix_en   = (state == st_fix);
  end

endmodule

// ==== logic/imuldiv_dispatch.sv ====
// ------------------------------
// request routing and response select
// ------------------------------

module imuldiv_dispatch import imuldiv_pkg::*; (
  input  logic               clk,
  input  logic               reset,

  input  imuldiv_req_t       req_msg,
  input  logic               req_val,
  output logic               req_rdy,

  // operands shared by both engines
  output logic [31:0]        op_a,
  output logic [31:0]        op_b,

  output logic               mul_req_val,
  input  logic               mul_req_rdy,
  output logic               div_req_val,
  input  logic               div_req_rdy,

  input  logic signed [63:0] mul_result,
  input  logic               mul_resp_val,
  output logic               mul_resp_rdy,
  input  div_result_t        div_result,
  input  logic               div_resp_val,
  output logic               div_resp_rdy,

  output imuldiv_resp_u      resp_msg,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // operation in flight
  logic        busy_q;
  imuldiv_fn_e fn_q;

  logic        is_mul;
  logic        req_fire;
  logic        resp_fire;

  // ------------------------------
  // request path, no registers
  // ------------------------------

  assign is_mul = (req_msg.fn == fn_mul);
  assign op_a   = req_msg.a;
  assign op_b   = req_msg.b;

  // one operation at a time
  assign req_rdy     = !busy_q && (is_mul ? mul_req_rdy : div_req_rdy);
  assign mul_req_val = req_val && !busy_q && is_mul;
  assign div_req_val = req_val && !busy_q && !is_mul;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      fn_q   <= fn_mul;
    end else if (req_fire) begin
      busy_q <= 1'b1;
      fn_q   <= req_msg.fn;
    end else if (resp_fire) begin
      busy_q <= 1'b0;
    end
  end

  // ------------------------------
  // response path
  // ------------------------------

  // only the owning engine sees resp_rdy
  assign mul_resp_rdy = resp_rdy && (fn_q == fn_mul);
  assign div_resp_rdy = resp_rdy && (fn_q == fn_div);
  assign resp_val     = (fn_q == fn_mul) ? mul_resp_val : div_resp_val;

  always_comb begin
    if (fn_q == fn_mul) begin
      resp_msg.product = mul_result;
    end else begin
      resp_msg.div = div_result;
    end
  end

endmodule

// ==== logic/imuldiv_top.sv ====
// ------------------------------
// multiply/divide unit top level
// ------------------------------

module imuldiv_top import imuldiv_pkg::*; (
  input  logic          clk,
  input  logic          reset,

  input  imuldiv_req_t  req_msg,
  input  logic          req_val,
  output logic          req_rdy,

  output imuldiv_resp_u resp_msg,
  output logic          resp_val,
  input  logic          resp_rdy
);

  // shared operands
  logic [31:0]        op_a;
  logic [31:0]        op_b;

  // multiplier link
  logic               mul_req_val;
  logic               mul_req_rdy;
  logic signed [63:0] mul_result;
  logic               mul_resp_val;
  logic               mul_resp_rdy;

  // divider link
  logic               div_req_val;
  logic               div_req_rdy;
  div_result_t        div_result;
  logic               div_resp_val;
  logic               div_resp_rdy;

  imuldiv_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_msg      (req_msg),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .op_a         (op_a),
    .op_b         (op_b),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .mul_result   (mul_result),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_result   (div_result),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .resp_msg     (resp_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

  int_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .a        (op_a),
    .b        (op_b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .result   (mul_result),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  int_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .a        (op_a),
    .b        (op_b),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .result   (div_result),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

endmodule

// ==== testbench/tb_model.svh ====
// ------------------------------
// reference model for expected responses and latency
// galois lfsr for stimulus and stalls
// ------------------------------

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected 64-bit response word for one request
function automatic logic [63:0] expected_response(input imuldiv_req_t req);
  longint sa;
  longint sb;
  longint q;
  longint r;
  // sign-extend so the arithmetic below is exact
  sa = longint'($signed(req.a));
  sb = longint'($signed(req.b));
  if (req.fn == fn_mul) begin
    // full signed product always fits in 64 bits
    return sa * sb;
  end
  if (sb == 0) begin
    // all-ones quotient, dividend handed back as remainder
    return {req.a, 32'hffff_ffff};
  end
  // truncating division, remainder keeps the dividend's sign
  q = sa / sb;
  r = sa % sb;
  // most negative over minus one wraps in the low half
  return {r[31:0], q[31:0]};
endfunction

// cycles from the accepting edge to the first edge with resp_val high
function automatic int expected_latency(input imuldiv_req_t req);
  if (req.fn == fn_mul) begin
    return 32;
  end
  if (req.b == 32'd0) begin
    return 1;
  end
  return 34;
endfunction

// one right-shift step, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

`endif

// ==== testbench/tb_imuldiv.sv ====
// ------------------------------
// testbench for the multiply/divide unit
// directed, latency and random back-pressure tests
// ------------------------------

module tb_imuldiv import imuldiv_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam time clk_period     = 4;
  localparam int  cycles_per_req = 40;
  localparam int  timeout_margin = 100;
  localparam int  n_random       = 150;

  logic          clk = 1'b0;
  logic          reset;
  imuldiv_req_t  req_msg;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_u resp_msg;
  logic          resp_val;
  logic          resp_rdy = 1'b1;

  // ------------------------------
  // scoreboard state
  // ------------------------------

  // pushed on request transfer, popped on response transfer
  logic [63:0]   exp_q[$];
  imuldiv_req_t  sent_q[$];

  imuldiv_req_t  mul_dir_q[$];
  imuldiv_req_t  div_dir_q[$];
  imuldiv_req_t  rand_q[$];

  int            cycle_count = 0;
  int            timeout_limit;
  logic          in_flight = 1'b0;
  time           accept_time = 0;
  logic          check_latency;
  logic          stall_en;
  logic [31:0]   lfsr_state = 32'h5a90;

  imuldiv_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  `include "tb_model.svh"

  // half of clk_period
  always #2 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0d ns %s got %0h expected %0h", $time, name, got, expected);
      abort_run();
    end
  endtask

  // one lfsr step per bit, newest bit lands in bit 0
  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic imuldiv_req_t make_req(input imuldiv_fn_e fn, input logic [31:0] a,
                                            input logic [31:0] b);
    imuldiv_req_t r;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // ------------------------------
  // request driver
  // ------------------------------

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_request(input imuldiv_req_t req);
    req_msg = req;
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    exp_q.push_back(expected_response(req));
    sent_q.push_back(req);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic run_queue(input imuldiv_req_t reqs[$]);
    foreach (reqs[i]) begin
      send_request(reqs[i]);
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic build_directed();
    // sign combinations, zero, minus one and the extremes
    mul_dir_q.push_back(make_req(fn_mul, 6, 7));
    mul_dir_q.push_back(make_req(fn_mul, -6, 7));
    mul_dir_q.push_back(make_req(fn_mul, 6, -7));
    mul_dir_q.push_back(make_req(fn_mul, -6, -7));
    mul_dir_q.push_back(make_req(fn_mul, 0, 123));
    mul_dir_q.push_back(make_req(fn_mul, 123, 0));
    mul_dir_q.push_back(make_req(fn_mul, -1, -1));
    mul_dir_q.push_back(make_req(fn_mul, -1, 5));
    mul_dir_q.push_back(make_req(fn_mul, 32'h8000_0000, 1));
    mul_dir_q.push_back(make_req(fn_mul, 32'h8000_0000, -1));
    mul_dir_q.push_back(make_req(fn_mul, 32'h8000_0000, 32'h8000_0000));
    mul_dir_q.push_back(make_req(fn_mul, 32'h7fff_ffff, 32'h7fff_ffff));
    mul_dir_q.push_back(make_req(fn_mul, 32'h7fff_ffff, 32'h8000_0000));
    mul_dir_q.push_back(make_req(fn_mul, 12345678, -87654321));
    // truncation and remainder sign
    div_dir_q.push_back(make_req(fn_div, 7, 2));
    div_dir_q.push_back(make_req(fn_div, -7, 2));
    div_dir_q.push_back(make_req(fn_div, 7, -2));
    div_dir_q.push_back(make_req(fn_div, -7, -2));
    div_dir_q.push_back(make_req(fn_div, 100, 7));
    div_dir_q.push_back(make_req(fn_div, 0, 5));
    div_dir_q.push_back(make_req(fn_div, 5, 7));
    div_dir_q.push_back(make_req(fn_div, -5, 7));
    div_dir_q.push_back(make_req(fn_div, 32'h8000_0000, -1));
    div_dir_q.push_back(make_req(fn_div, 32'h8000_0000, 1));
    div_dir_q.push_back(make_req(fn_div, 32'h7fff_ffff, -1));
    div_dir_q.push_back(make_req(fn_div, 32'h8000_0000, 32'h7fff_ffff));
    div_dir_q.push_back(make_req(fn_div, 123456789, 1000));
    // zero divisors
    div_dir_q.push_back(make_req(fn_div, 42, 0));
    div_dir_q.push_back(make_req(fn_div, -42, 0));
    div_dir_q.push_back(make_req(fn_div, 0, 0));
    div_dir_q.push_back(make_req(fn_div, 32'h8000_0000, 0));
  endtask

  task automatic build_random(input int n);
    logic [31:0] sel;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] shape;
    for (int i = 0; i < n; i++) begin
      draw_bits(1, sel);
      draw_bits(32, a);
      draw_bits(32, b);
      draw_bits(2, shape);
      // bias divisors toward small values, zero and minus one
      case (shape[1:0])
        2'd2: b = {{24{b[7]}}, b[7:0]};
        2'd3: b = b[0] ? 32'hffff_ffff : 32'd0;
        default: b = b;
      endcase
      rand_q.push_back(make_req(sel[0] ? fn_div : fn_mul, a, b));
    end
  endtask

  // ------------------------------
  // response checking
  // ------------------------------

  task automatic check_response(input imuldiv_req_t req, input logic [63:0] expected,
                                input imuldiv_resp_u got);
    logic [31:0] recombined;
    if (req.fn == fn_mul) begin
      check_value("resp_msg.product", 64'(got.product), expected);
    end else begin
      // quotient times divisor plus remainder gives back the dividend
      if (req.b != 32'd0) begin
        recombined = got.div.quo * req.b + got.div.rem;
        check_value("quo*b+rem", 64'(recombined), 64'(req.a));
      end
      check_value("resp_msg.div.quo", 64'(got.div.quo), 64'(expected[31:0]));
      check_value("resp_msg.div.rem", 64'(got.div.rem), 64'(expected[63:32]));
    end
  endtask

  // values read here are the ones in place just before the edge
  always @(posedge clk) begin
    imuldiv_req_t req;
    logic [63:0]  expected;
    time          lat;
    if (!reset) begin
      // no new request while one is pending, no response without one
      if (in_flight) begin
        check_value("req_rdy", 64'(req_rdy), 64'd0);
      end else begin
        check_value("resp_val", 64'(resp_val), 64'd0);
      end
      if (req_val && req_rdy) begin
        in_flight   = 1'b1;
        accept_time = $time;
      end else if (resp_val) begin
        // a stalled response must already hold the right value
        check_response(sent_q[0], exp_q[0], resp_msg);
        if (resp_rdy) begin
          req      = sent_q.pop_front();
          expected = exp_q.pop_front();
          if (check_latency) begin
            lat = ($time - accept_time) / clk_period;
            check_value("latency", 64'(lat), 64'(expected_latency(req)));
          end
          in_flight = 1'b0;
        end
      end
    end
  end

  // random stalls, roughly one cycle in four
  always @(negedge clk) begin
    logic [31:0] bits;
    if (stall_en) begin
      draw_bits(2, bits);
      resp_rdy = (bits[1:0] != 2'b11);
    end
  end

  // ------------------------------
  // timeout
  // ------------------------------

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      $display("run timed out after %0d cycles with %0d responses outstanding",
               cycle_count, exp_q.size());
      abort_run();
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    reset         = 1'b1;
    req_val       = 1'b0;
    req_msg       = '0;
    stall_en      = 1'b0;
    check_latency = 1'b1;

    build_directed();
    build_random(n_random);
    timeout_limit = (mul_dir_q.size() + div_dir_q.size() + rand_q.size()) * cycles_per_req
                    + timeout_margin;

    // two rising edges in reset
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("req_rdy", 64'(req_rdy), 64'd1);
    check_value("resp_val", 64'(resp_val), 64'd0);

    // directed multiply and divide with resp_rdy high, latency checked
    run_queue(mul_dir_q);
    wait_drained();
    run_queue(div_dir_q);
    wait_drained();

    // random mix under back-pressure
    check_latency = 1'b0;
    @(posedge clk);
    stall_en = 1'b1;
    @(negedge clk);
    run_queue(rand_q);
    wait_drained();

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+testbench
common/imuldiv_pkg.sv
mul/int_mul_iterative.sv
div/int_div_iterative.sv
logic/imuldiv_dispatch.sv
logic/imuldiv_top.sv
testbench/tb_imuldiv.sv

// ==== Makefile ====
# Verilator build and run for the multiply/divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_imuldiv
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All checks passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
